// File: files.f
+incdir+verification
logic/gamePkg.sv
logic/busPkg.sv
logic/pickupRegisters.sv
logic/pickupController.sv
logic/pickupMotion.sv
logic/pickupGeometry.sv
logic/pickupSystem.sv
verification/pickupSystemTb.sv

// File: run.sh
#!/bin/sh
# build and run the pickup testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module pickupSystemTb \
	-f files.f --Mdir obj_dir -o simPickup > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/simPickup > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
fi

if grep -q "No errors" sim.log; then
	exit 0
fi
exit 1

// File: verification/pickupSystemTasks.svh
`ifndef PICKUP_SYSTEM_TASKS_SVH
`define PICKUP_SYSTEM_TASKS_SVH

// stop the run on the first failure
task automatic failWith(input string what);
	errorCount++;
	$display("%s", what);
	$display("Errors found");
	$fatal(1);
endtask

task automatic compareValue(input string testName, input int expected, input int actual);
	if (expected !== actual) begin
		failWith($sformatf("mismatch %s expected %0d actual %0d", testName, expected, actual));
	end
endtask

// called on a falling edge, returns on a falling edge
task automatic busWrite(input logic [2:0] adr, input logic [15:0] dat);
	int waited;
	wbReq.cyc = 1'b1;
	wbReq.stb = 1'b1;
	wbReq.we = 1'b1;
	wbReq.adr = adr;
	wbReq.dat = dat;
	waited = 0;
	do begin
		@(negedge clk);
		waited++;
	end while (!wbRsp.ack && waited < 20);
	if (!wbRsp.ack) failWith("bus write got no ack");
	wbReq = '0;
	@(negedge clk); // stb low for a cycle so the slave can ack again
endtask

// holdCycles keeps stb up after the ack to count any extra acks
task automatic busRead(input logic [2:0] adr, output logic [15:0] dat, input int holdCycles);
	int waited;
	int extraAcks;
	wbReq.cyc = 1'b1;
	wbReq.stb = 1'b1;
	wbReq.we = 1'b0;
	wbReq.adr = adr;
	wbReq.dat = '0;
	waited = 0;
	extraAcks = 0;
	do begin
		@(negedge clk);
		waited++;
	end while (!wbRsp.ack && waited < 20);
	if (!wbRsp.ack) failWith("bus read got no ack");
	dat = wbRsp.dat; // valid while ack is high
	repeat (holdCycles) begin
		@(negedge clk);
		if (wbRsp.ack) extraAcks++;
	end
	wbReq = '0;
	@(negedge clk);
	if (wbRsp.ack) extraAcks++;
	if (extraAcks != 0) failWith("bus gave more than one ack for a single strobe");
endtask

// frame pulses counted on the rising edge, read here on the falling edge
task automatic waitFrames(input int frames);
	int target;
	int waited;
	target = frameCount + frames;
	waited = 0;
	while (frameCount < target && waited < frames * 20 + 60) begin
		@(negedge clk);
		waited++;
	end
	if (frameCount < target) failWith("frame pulses stopped arriving");
endtask

task automatic waitActive(input logic level, input int limit, input string what);
	int waited;
	waited = 0;
	while (pickupActive !== level && waited < limit) begin
		@(negedge clk);
		waited++;
	end
	if (pickupActive !== level) failWith(what);
endtask

`endif

// File: verification/pickupSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module pickupSystemTb
	import gamePkg::*, busPkg::*;
();

	localparam int ROWS = 5;
	localparam int MODE_MISS = 0; // let it fall out
	localparam int MODE_CATCH = 1; // player waits on the path
	localparam int MODE_DISABLE = 2; // disable while falling

	logic clk;
	logic resetN;
	wbReqT wbReq;
	wbRspT wbRsp;
	logic startOfFrame;
	boxT playerBox;
	coordT pixel;
	logic drawRequest;
	logic pickupActive;

	int errorCount = 0;
	int frameCount = 0;

	// test table, expected columns filled by the model
	string rowName [ROWS];
	int rowSpeed [ROWS];
	int rowInterval [ROWS];
	int rowMode [ROWS];
	int rowFrames [ROWS];
	int expY [ROWS];
	int expCatches [ROWS];
	int expMisses [ROWS];
	int expColumn [ROWS];

	`include "pickupSystemTasks.svh"

	pickupSystem i_pickupSystem (
		.clk(clk),
		.resetN(resetN),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.startOfFrame(startOfFrame),
		.playerBox(playerBox),
		.pixel(pixel),
		.drawRequest(drawRequest),
		.pickupActive(pickupActive)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// one cycle frame pulse every 20 cycles
	initial begin
		startOfFrame = 1'b0;
		forever begin
			repeat (19) @(negedge clk);
			startOfFrame = 1'b1;
			@(negedge clk);
			startOfFrame = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (startOfFrame) frameCount <= frameCount + 1;
	end

	// fibonacci shift with taps 8,6,5,4 counted from one
	function automatic logic [7:0] advanceLfsr(input logic [7:0] value);
		logic feedback;
		feedback = value[8 - 1] ^ value[6 - 1] ^ value[5 - 1] ^ value[4 - 1];
		return {value[6:0], feedback};
	endfunction

	task automatic addRow(input int idx, input string name, input int speed, input int interval,
		input int mode, input int frames);
		rowName[idx] = name;
		rowSpeed[idx] = speed;
		rowInterval[idx] = interval;
		rowMode[idx] = mode;
		rowFrames[idx] = frames;
	endtask

	// step per frame is 64 plus 32 per speed level, in 1/64 pixel
	task automatic buildModel();
		logic [7:0] lfsr;
		int catches;
		int misses;
		lfsr = 8'hA5;
		catches = 0;
		misses = 0;
		for (int i = 0; i < ROWS; i++) begin
			expColumn[i] = 2 * int'(lfsr);
			lfsr = advanceLfsr(lfsr);
			expY[i] = (rowFrames[i] * (64 + 32 * rowSpeed[i])) / 64;
			if (rowMode[i] == MODE_CATCH) catches++;
			else misses++;
			expCatches[i] = catches;
			expMisses[i] = misses;
		end
	endtask

	// pixel driven on a falling edge, drawRequest checked one cycle later
	task automatic probePixel(input string name, input int x, input int y, input int expected);
		pixel.x = 11'(x);
		pixel.y = 11'(y);
		@(negedge clk);
		compareValue(name, expected, int'(drawRequest));
	endtask

	// probes the square edges while the position holds between frame pulses
	task automatic checkSquare(input string name, input int x, input int y);
		probePixel({name, " corner"}, x, y, 1);
		probePixel({name, " left of corner"}, x - 1, y, 0);
		probePixel({name, " above corner"}, x, y - 1, 0);
		probePixel({name, " far corner"}, x + 31, y + 31, 1);
		probePixel({name, " right of square"}, x + 32, y + 31, 0);
	endtask

	task automatic placePlayerFar();
		playerBox.topLeft.x = 11'sd0;
		playerBox.topLeft.y = -11'sd200; // above the screen, never touched
		playerBox.size = 7'd10;
	endtask

	initial begin
		logic [15:0] readValue;
		addRow(0, "spawnSpeed0", 0, 2, MODE_MISS, 10);
		addRow(1, "fallSpeed5", 5, 3, MODE_MISS, 7);
		addRow(2, "catchSpeed3", 3, 2, MODE_CATCH, 3);
		addRow(3, "fallSpeed7", 7, 1, MODE_MISS, 9);
		addRow(4, "disableSpeed2", 2, 2, MODE_DISABLE, 4);
		buildModel();

		resetN = 1'b0;
		wbReq = '0;
		pixel = '0;
		placePlayerFar();
		repeat (8) @(negedge clk);
		resetN = 1'b1;
		@(negedge clk);

		compareValue("reset pickupActive", 0, int'(pickupActive));
		compareValue("reset drawRequest", 0, int'(drawRequest));
		busRead(REG_CATCHES, readValue, 0);
		compareValue("reset catches", 0, int'(readValue));
		busRead(REG_MISSES, readValue, 0);
		compareValue("reset misses", 0, int'(readValue));
		busRead(3'd7, readValue, 3); // held strobe must see one ack
		compareValue("unused address", 0, int'(readValue));

		busWrite(REG_CONTROL, 16'h000A); // speed 5, still disabled
		busRead(REG_CONTROL, readValue, 0);
		compareValue("control readback", 'h000A, int'(readValue));
		busWrite(REG_INTERVAL, 16'h0033);
		busRead(REG_INTERVAL, readValue, 0);
		compareValue("interval readback", 'h0033, int'(readValue));

		for (int i = 0; i < ROWS; i++) begin
			if (rowMode[i] == MODE_CATCH) begin
				playerBox.topLeft.x = 11'(expColumn[i]);
				playerBox.topLeft.y = 11'sd200; // well below the checked frames
				playerBox.size = 7'd40;
			end else begin
				placePlayerFar();
			end
			busWrite(REG_INTERVAL, 16'(rowInterval[i]));
			busWrite(REG_CONTROL, 16'((rowSpeed[i] << 1) | 1));
			waitActive(1'b1, (rowInterval[i] + 2) * 20 + 40, {rowName[i], " never spawned"});
			checkSquare({rowName[i], " spawn"}, expColumn[i], 0);
			waitFrames(rowFrames[i]);
			checkSquare({rowName[i], " fall"}, expColumn[i], expY[i]);
			if (rowMode[i] == MODE_DISABLE) begin
				busWrite(REG_CONTROL, 16'(rowSpeed[i] << 1)); // current pickup keeps falling
				waitFrames(2);
				compareValue({rowName[i], " kept falling"}, 1, int'(pickupActive));
			end
			waitActive(1'b0, 20000, {rowName[i], " pickup never left"});
			if (rowMode[i] != MODE_DISABLE) begin
				busWrite(REG_CONTROL, 16'(rowSpeed[i] << 1)); // hold off the next spawn
			end else begin
				repeat (rowInterval[i] * 4 * 20) begin
					@(negedge clk);
					if (pickupActive) failWith("pickup spawned while disabled");
				end
			end
			placePlayerFar();
			busRead(REG_CATCHES, readValue, 0);
			compareValue({rowName[i], " catches"}, expCatches[i], int'(readValue));
			busRead(REG_MISSES, readValue, 0);
			compareValue({rowName[i], " misses"}, expMisses[i], int'(readValue));
			busRead(REG_STATUS, readValue, 0);
			compareValue({rowName[i], " status"}, 0, int'(readValue[0]));
			compareValue({rowName[i], " drawRequest idle"}, 0, int'(drawRequest));
		end

		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/pickupSystem.sv
`timescale 1ns/1ps
`default_nettype none

module pickupSystem
	import gamePkg::*, busPkg::*;
#(
	parameter int PICKUP_SIZE = 32,
	parameter logic [7:0] LFSR_SEED = 8'hA5
) (
	input logic clk,
	input logic resetN,
	input wbReqT wbReq,
	output wbRspT wbRsp,
	input logic startOfFrame, // one pulse per video frame
	input boxT playerBox,
	input coordT pixel, // current scan position
	output logic drawRequest, // paint the pickup color here
	output logic pickupActive
);

	logic enable;
	speedT speed;
	logic [7:0] interval;
	logic [15:0] catches, misses;
	logic deploy, remove, hit;
	logic [7:0] spawnColumn;
	coordT position;

	pickupRegisters i_pickupRegisters (
		.clk(clk),
		.resetN(resetN),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.enable(enable),
		.speed(speed),
		.interval(interval),
		.catches(catches),
		.misses(misses),
		.active(pickupActive)
	);

	pickupController #(.LFSR_SEED(LFSR_SEED)) i_pickupController (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.enable(enable),
		.interval(interval),
		.hit(hit),
		.isActive(pickupActive),
		.deploy(deploy),
		.remove(remove),
		.spawnColumn(spawnColumn),
		.catches(catches),
		.misses(misses)
	);

	pickupMotion #(.PICKUP_SIZE(PICKUP_SIZE)) i_pickupMotion (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.deploy(deploy),
		.remove(remove),
		.spawnColumn(spawnColumn),
		.speed(speed),
		.position(position),
		.isActive(pickupActive)
	);

	pickupGeometry #(.PICKUP_SIZE(PICKUP_SIZE)) i_pickupGeometry (
		.position(position),
		.isActive(pickupActive),
		.playerBox(playerBox),
		.pixel(pixel),
		.hit(hit),
		.drawRequest(drawRequest)
	);

endmodule

`default_nettype wire

// File: logic/pickupGeometry.sv
`timescale 1ns/1ps
`default_nettype none

module pickupGeometry
	import gamePkg::*;
#(
	parameter int PICKUP_SIZE = 32 // edge of the square in pixels
) (
	input coordT position, // pickup top left
	input logic isActive,
	input boxT playerBox,
	input coordT pixel, // current scan position
	output logic hit, // pickup touches the player
	output logic drawRequest // pixel lies inside the pickup
);

	localparam logic signed [11:0] SIZE = 12'(PICKUP_SIZE);

	// one extra bit so right and bottom edges never wrap
	logic signed [11:0] pickLeft, pickRight, pickTop, pickBottom;
	logic signed [11:0] playerLeft, playerRight, playerTop, playerBottom;
	logic signed [11:0] pixelX, pixelY;
	logic overlapX, overlapY;

	always_comb begin
		pickLeft = {position.x[10], position.x};
		pickTop = {position.y[10], position.y};
		pickRight = pickLeft + SIZE;
		pickBottom = pickTop + SIZE;
		playerLeft = {playerBox.topLeft.x[10], playerBox.topLeft.x};
		playerTop = {playerBox.topLeft.y[10], playerBox.topLeft.y};
		playerRight = playerLeft + {5'd0, playerBox.size};
		playerBottom = playerTop + {5'd0, playerBox.size};
		pixelX = {pixel.x[10], pixel.x};
		pixelY = {pixel.y[10], pixel.y};
	end

	// touching edges do not count
	assign overlapX = (pickLeft < playerRight) && (playerLeft < pickRight);
	assign overlapY = (pickTop < playerBottom) && (playerTop < pickBottom);
	assign hit = isActive && overlapX && overlapY;

	// left and top edges belong to the square
	assign drawRequest = isActive
		&& (pixelX >= pickLeft) && (pixelX < pickRight)
		&& (pixelY >= pickTop) && (pixelY < pickBottom);

endmodule

`default_nettype wire

// File: logic/pickupMotion.sv
`timescale 1ns/1ps
`default_nettype none

module pickupMotion
	import gamePkg::*;
#(
	parameter int PICKUP_SIZE = 32 // edge of the square in pixels
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame, // one pulse per video frame
	input logic deploy, // place a new pickup at the top
	input logic remove, // caught, park it offscreen
	input logic [7:0] spawnColumn,
	input speedT speed,
	output coordT position, // top left corner in whole pixels
	output logic isActive
);

	localparam int FRACTION_BITS = $clog2(FIXED_POINT_MULTIPLIER);
	localparam int Y_LIMIT = (SCREEN_HEIGHT - 1) * FIXED_POINT_MULTIPLIER; // last row to move from
	localparam int PARK_X = SCREEN_WIDTH * FIXED_POINT_MULTIPLIER;
	localparam int PARK_Y = SCREEN_HEIGHT * FIXED_POINT_MULTIPLIER;
	localparam int MAX_SPAWN_X = SCREEN_WIDTH - PICKUP_SIZE; // square stays on screen

	logic signed [17:0] xFixed, yFixed; // top left in 1/64 pixel
	logic signed [17:0] step;
	logic [9:0] spawnX; // spawn x in whole pixels

	// 64 plus 32 per speed level
	assign step = 18'(FIXED_POINT_MULTIPLIER + speed * (FIXED_POINT_MULTIPLIER / 2));

	always_comb begin
		spawnX = {1'b0, spawnColumn, 1'b0}; // column times two
		if (spawnX > 10'(MAX_SPAWN_X)) begin
			spawnX = 10'(MAX_SPAWN_X);
		end
	end

	// remove wins over the frame step, the frame step wins over deploy
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xFixed <= 18'(PARK_X);
			yFixed <= 18'(PARK_Y);
			isActive <= 1'b0;
		end else if (remove) begin
			xFixed <= 18'(PARK_X);
			yFixed <= 18'(PARK_Y);
			isActive <= 1'b0;
		end else if (startOfFrame && isActive) begin
			if (yFixed <= Y_LIMIT) begin
				yFixed <= yFixed + step;
			end else begin
				isActive <= 1'b0; // fell past the bottom
			end
		end else if (deploy) begin
			xFixed <= 18'(spawnX * FIXED_POINT_MULTIPLIER);
			yFixed <= '0;
			isActive <= 1'b1;
		end
	end

	// drop the fraction
	assign position.x = 11'(xFixed >>> FRACTION_BITS);
	assign position.y = 11'(yFixed >>> FRACTION_BITS);

endmodule

`default_nettype wire

// File: logic/pickupController.sv
`timescale 1ns/1ps
`default_nettype none

module pickupController #(
	parameter logic [7:0] LFSR_SEED = 8'hA5 // first spawn column is twice this
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame, // one pulse per video frame
	input logic enable, // new spawns allowed
	input logic [7:0] interval, // frames to wait before a spawn
	input logic hit, // pickup overlaps the player
	input logic isActive, // pickup is falling
	output logic deploy, // start a new pickup
	output logic remove, // take the pickup off after a catch
	output logic [7:0] spawnColumn, // half of the spawn x
	output logic [15:0] catches,
	output logic [15:0] misses
);

	logic [7:0] frameCount; // frames waited so far
	logic [7:0] lfsr;
	logic lfsrFeedback;
	logic frameDue; // this frame pulse reaches the interval
	logic isActiveDly; // for the falling edge of isActive
	logic removeDly; // remove lines up with that falling edge

	// taps 8,6,5,4 give a maximal length sequence
	assign lfsrFeedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	// interval 0 behaves like 1
	assign frameDue = ({1'b0, frameCount} + 9'd1) >= {1'b0, interval};

	assign spawnColumn = lfsr; // sampled by motion on the deploy cycle

	// spawn scheduling
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frameCount <= '0;
			deploy <= 1'b0;
			lfsr <= LFSR_SEED;
		end else begin
			deploy <= 1'b0; // single cycle pulse
			if (!enable || isActive || deploy) begin
				frameCount <= '0; // count only while idle and enabled
			end else if (startOfFrame) begin
				if (frameDue) begin
					deploy <= 1'b1;
					frameCount <= '0;
				end else begin
					frameCount <= frameCount + 8'd1;
				end
			end
			if (deploy) begin
				lfsr <= {lfsr[6:0], lfsrFeedback}; // advance after the column is used
			end
		end
	end

	// catch and miss bookkeeping
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			remove <= 1'b0;
			catches <= '0;
			misses <= '0;
			isActiveDly <= 1'b0;
			removeDly <= 1'b0;
		end else begin
			remove <= 1'b0;
			isActiveDly <= isActive;
			removeDly <= remove;
			// hit stays high until the pickup parks, so fire once
			if (hit && isActive && !remove) begin
				remove <= 1'b1;
				catches <= catches + 16'd1;
			end
			// left the screen on its own
			if (isActiveDly && !isActive && !removeDly) begin
				misses <= misses + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/pickupRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module pickupRegisters
	import gamePkg::*, busPkg::*;
(
	input logic clk,
	input logic resetN,
	input wbReqT wbReq, // host bus request
	output wbRspT wbRsp, // host bus response
	output logic enable, // spawning allowed
	output speedT speed, // falling speed level
	output logic [7:0] interval, // frames between spawns
	input logic [15:0] catches,
	input logic [15:0] misses,
	input logic active // a pickup is on screen
);

	logic request; // a valid bus cycle is presented
	logic served; // this cycle already got its ack
	logic ack;
	logic accept; // first cycle of a new request
	logic [15:0] readData;

	assign request = wbReq.cyc && wbReq.stb;
	assign accept = request && !served;

	// one ack per strobe
	// served stays high until the master drops stb
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			served <= 1'b0;
			ack <= 1'b0;
		end else begin
			served <= request;
			ack <= accept;
		end
	end

	// writes land on the same edge that raises ack
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			enable <= 1'b0;
			speed <= '0;
			interval <= '0;
		end else if (accept && wbReq.we) begin
			case (wbReq.adr)
				REG_CONTROL: begin
					enable <= wbReq.dat[0];
					speed <= wbReq.dat[3:1];
				end
				REG_INTERVAL: interval <= wbReq.dat[7:0];
				default: ; // counters and status ignore writes
			endcase
		end
	end

	// read mux, master holds adr through the ack cycle
	always_comb begin
		case (wbReq.adr)
			REG_CONTROL: readData = {12'd0, speed, enable};
			REG_INTERVAL: readData = {8'd0, interval};
			REG_CATCHES: readData = catches;
			REG_MISSES: readData = misses;
			REG_STATUS: readData = {15'd0, active};
			default: readData = '0; // unused addresses read zero
		endcase
	end

	assign wbRsp.ack = ack;
	assign wbRsp.dat = readData;

endmodule

`default_nettype wire

// File: logic/busPkg.sv
`default_nettype none

package busPkg;

	// wishbone classic request from the host
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [2:0] adr; // word address into the register map
		logic [15:0] dat; // write data
	} wbReqT;

	// wishbone classic response back to the host
	typedef struct packed {
		logic ack;
		logic [15:0] dat; // read data, valid with ack
	} wbRspT;

	// register map
	parameter logic [2:0] REG_CONTROL = 3'd0; // bit 0 enable, bits 3:1 speed
	parameter logic [2:0] REG_INTERVAL = 3'd1; // frames between spawns
	parameter logic [2:0] REG_CATCHES = 3'd2; // read only
	parameter logic [2:0] REG_MISSES = 3'd3; // read only
	parameter logic [2:0] REG_STATUS = 3'd4; // bit 0 pickup active, read only

endpackage

`default_nettype wire

// File: logic/gamePkg.sv
`default_nettype none

package gamePkg;

	// visible area in pixels
	parameter int SCREEN_WIDTH = 640;
	parameter int SCREEN_HEIGHT = 480;

	// positions are kept in 1/64 pixel units
	// the multiplier must stay a power of two so the divide is a shift
	parameter int FIXED_POINT_MULTIPLIER = 64;

	// falling speed per frame in 1/64 pixel is 64 plus 32 times the speed level
	// speed 0 moves one pixel per frame and speed 7 moves four and a half
	typedef logic [2:0] speedT;

	// screen coordinate in whole pixels
	// signed so parked or partly offscreen objects still compare correctly
	typedef struct packed {
		logic signed [10:0] x;
		logic signed [10:0] y;
	} coordT;

	// square object on the screen
	typedef struct packed {
		coordT topLeft;
		logic [6:0] size; // edge length in pixels
	} boxT;

endpackage

`default_nettype wire
